// File: filelist.f
rtl/mem_sys_pkg.sv
rtl/axi_lite_if.sv
rtl/uncached_data_port.sv
rtl/axi_lite_bank_decode.sv
rtl/axi_lite_resp_merge.sv
rtl/axi_lite_ram_bank.sv
rtl/data_mem_top.sv
tests/data_mem_tb.sv

// File: rtl/axi_lite_bank_decode.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_bank_decode #(
    parameter int NUM_BANKS = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    axi_lite_if.slave  up,
    axi_lite_if.master down [NUM_BANKS]
);

    localparam int BANK_BITS = $clog2(NUM_BANKS);

    // Bank picked by the word bits just above the byte offset
    logic [BANK_BITS-1:0] aw_sel;
    logic [BANK_BITS-1:0] ar_sel;
    // Bank of the last accepted write address, used for W
    logic [BANK_BITS-1:0] w_sel;

    // Ready lines gathered from the bank row
    logic [NUM_BANKS-1:0] bank_awready;
    logic [NUM_BANKS-1:0] bank_wready;
    logic [NUM_BANKS-1:0] bank_arready;

    assign aw_sel = up.awaddr[mem_sys_pkg::OFFSET_W +: BANK_BITS];
    assign ar_sel = up.araddr[mem_sys_pkg::OFFSET_W +: BANK_BITS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w_sel <= '0;
        end else if (up.awvalid && up.awready) begin
            w_sel <= aw_sel;
        end
    end

    // ==================================================
    // Fan out to the bank row
    // ==================================================
    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_route
        // Payloads go to every bank, valids only to the chosen one
        assign down[g].awaddr  = up.awaddr;
        assign down[g].awvalid = up.awvalid && (aw_sel == BANK_BITS'(g));
        assign down[g].wdata   = up.wdata;
        assign down[g].wstrb   = up.wstrb;
        assign down[g].wvalid  = up.wvalid && (w_sel == BANK_BITS'(g));
        assign down[g].araddr  = up.araddr;
        assign down[g].arvalid = up.arvalid && (ar_sel == BANK_BITS'(g));

        assign bank_awready[g] = down[g].awready;
        assign bank_wready[g]  = down[g].wready;
        assign bank_arready[g] = down[g].arready;
    end

    // Ready comes back from the same bank the valid went to
    assign up.awready = bank_awready[aw_sel];
    assign up.wready  = bank_wready[w_sel];
    assign up.arready = bank_arready[ar_sel];

endmodule

`default_nettype wire

// File: rtl/axi_lite_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axi_lite_if;

    // Write address channel
    mem_sys_pkg::addr_t awaddr;
    logic               awvalid;
    logic               awready;
    // Write data channel
    mem_sys_pkg::word_t wdata;
    mem_sys_pkg::strb_t wstrb;
    logic               wvalid;
    logic               wready;
    // Write response channel
    logic [1:0]         bresp;
    logic               bvalid;
    logic               bready;
    // Read address channel
    mem_sys_pkg::addr_t araddr;
    logic               arvalid;
    logic               arready;
    // Read data channel
    mem_sys_pkg::word_t rdata;
    logic [1:0]         rresp;
    logic               rvalid;
    logic               rready;

    modport master (
        output awaddr, awvalid, input awready,
        output wdata, wstrb, wvalid, input wready,
        input bresp, bvalid, output bready,
        output araddr, arvalid, input arready,
        input rdata, rresp, rvalid, output rready
    );

    modport slave (
        input awaddr, awvalid, output awready,
        input wdata, wstrb, wvalid, output wready,
        output bresp, bvalid, input bready,
        input araddr, arvalid, output arready,
        output rdata, rresp, rvalid, input rready
    );

endinterface

`default_nettype wire

// File: rtl/axi_lite_ram_bank.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_ram_bank #(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_WORDS = 64
) (
    input  logic      clk,
    input  logic      rst_n,
    axi_lite_if.slave bus
);

    localparam int BANK_BITS = $clog2(NUM_BANKS);
    localparam int WORD_BITS = $clog2(BANK_WORDS);
    // Word index sits above byte offset and bank bits
    localparam int IDX_LSB   = mem_sys_pkg::OFFSET_W + BANK_BITS;

    mem_sys_pkg::word_t mem [BANK_WORDS];

    // Write address taken, waiting for its data
    logic                 aw_taken;
    logic [WORD_BITS-1:0] aw_idx;
    logic                 bvalid_q;
    logic                 rvalid_q;
    mem_sys_pkg::word_t   rdata_q;

    logic aw_fire;
    logic w_fire;
    logic ar_fire;

    // Idle means no address held and no response waiting
    assign bus.awready = !aw_taken && !bvalid_q;
    assign bus.wready  = aw_taken;
    assign bus.arready = !rvalid_q;

    assign aw_fire = bus.awvalid && bus.awready;
    assign w_fire  = bus.wvalid && bus.wready;
    assign ar_fire = bus.arvalid && bus.arready;

    assign bus.bvalid = bvalid_q;
    assign bus.bresp  = mem_sys_pkg::RESP_OKAY;
    assign bus.rvalid = rvalid_q;
    assign bus.rresp  = mem_sys_pkg::RESP_OKAY;
    assign bus.rdata  = rdata_q;

    // ==================================================
    // Handshake flags
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            aw_taken <= 1'b0;
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (aw_fire) begin
                aw_taken <= 1'b1;
            end else if (w_fire) begin
                aw_taken <= 1'b0;
            end
            // Response held until the master takes it
            if (w_fire) begin
                bvalid_q <= 1'b1;
            end else if (bus.bready) begin
                bvalid_q <= 1'b0;
            end
            if (ar_fire) begin
                rvalid_q <= 1'b1;
            end else if (bus.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // ==================================================
    // Word store with byte lanes
    // ==================================================
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            aw_idx <= bus.awaddr[IDX_LSB +: WORD_BITS];
        end
        if (w_fire) begin
            for (int b = 0; b < mem_sys_pkg::STRB_W; b++) begin
                if (bus.wstrb[b]) begin
                    mem[aw_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
        // Upper address bits dropped here, so addresses alias
        if (ar_fire) begin
            rdata_q <= mem[bus.araddr[IDX_LSB +: WORD_BITS]];
        end
    end

endmodule

`default_nettype wire

// File: rtl/axi_lite_resp_merge.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_resp_merge #(
    parameter int NUM_BANKS = 4
) (
    axi_lite_if.slave  up,
    axi_lite_if.master down [NUM_BANKS]
);

    // Response channels gathered from the bank row
    logic [NUM_BANKS-1:0] bank_bvalid;
    logic [NUM_BANKS-1:0] bank_rvalid;
    logic [1:0]           bank_bresp [NUM_BANKS];
    logic [1:0]           bank_rresp [NUM_BANKS];
    mem_sys_pkg::word_t   bank_rdata [NUM_BANKS];

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_collect
        assign bank_bvalid[g] = down[g].bvalid;
        assign bank_bresp[g]  = down[g].bresp;
        assign bank_rvalid[g] = down[g].rvalid;
        assign bank_rresp[g]  = down[g].rresp;
        assign bank_rdata[g]  = down[g].rdata;
        // Ready goes to all, only the bank holding a response reacts
        assign down[g].bready = up.bready;
        assign down[g].rready = up.rready;
    end

    // ==================================================
    // One transaction in flight, so at most one valid
    // ==================================================
    always_comb begin
        up.bvalid = |bank_bvalid;
        up.bresp  = mem_sys_pkg::RESP_OKAY;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (bank_bvalid[i]) begin
                up.bresp = bank_bresp[i];
            end
        end
    end

    always_comb begin
        up.rvalid = |bank_rvalid;
        up.rresp  = mem_sys_pkg::RESP_OKAY;
        up.rdata  = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (bank_rvalid[i]) begin
                up.rresp = bank_rresp[i];
                up.rdata = bank_rdata[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/data_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem_top #(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_WORDS = 64
) (
    input  logic               clk,
    input  logic               rst_n,
    input  mem_sys_pkg::addr_t address,
    input  mem_sys_pkg::word_t write_data,
    input  logic               read_enable,
    input  logic               write_enable,
    input  mem_sys_pkg::strb_t byte_enable,
    output mem_sys_pkg::word_t read_data,
    output logic               stall
);

    // Port to interconnect, then one bus per bank
    axi_lite_if m_bus ();
    axi_lite_if bank_bus [NUM_BANKS] ();

    uncached_data_port u_port (
        .clk          (clk),
        .rst_n        (rst_n),
        .address      (address),
        .write_data   (write_data),
        .read_enable  (read_enable),
        .write_enable (write_enable),
        .byte_enable  (byte_enable),
        .read_data    (read_data),
        .stall        (stall),
        .bus          (m_bus)
    );

    // Request channels out, response channels back
    axi_lite_bank_decode #(
        .NUM_BANKS (NUM_BANKS)
    ) u_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .up    (m_bus),
        .down  (bank_bus)
    );

    axi_lite_resp_merge #(
        .NUM_BANKS (NUM_BANKS)
    ) u_merge (
        .up   (m_bus),
        .down (bank_bus)
    );

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        axi_lite_ram_bank #(
            .NUM_BANKS  (NUM_BANKS),
            .BANK_WORDS (BANK_WORDS)
        ) u_bank (
            .clk   (clk),
            .rst_n (rst_n),
            .bus   (bank_bus[g])
        );
    end

endmodule

`default_nettype wire

// File: rtl/mem_sys_pkg.sv
`default_nettype none

package mem_sys_pkg;

    // ==================================================
    // Bus widths
    // ==================================================
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    // Byte offset bits inside one word
    localparam int OFFSET_W = $clog2(STRB_W);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;
    typedef logic [STRB_W-1:0] strb_t;

    // AXI response code, banks always answer with this one
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // ==================================================
    // Data port FSM states
    // ==================================================
    typedef enum logic [2:0] {
        IDLE,
        SEND_WRITE_ADDR,
        SEND_WRITE_DATA,
        WAIT_WRITE_RESP,
        SEND_READ_ADDR,
        RECV_READ_DATA
    } port_state_t;

endpackage

`default_nettype wire

// File: rtl/uncached_data_port.sv
`timescale 1ns/1ps
`default_nettype none

module uncached_data_port (
    input  logic               clk,
    input  logic               rst_n,
    // CPU side
    input  mem_sys_pkg::addr_t address,
    input  mem_sys_pkg::word_t write_data,
    input  logic               read_enable,
    input  logic               write_enable,
    input  mem_sys_pkg::strb_t byte_enable,
    output mem_sys_pkg::word_t read_data,
    output logic               stall,
    // AXI-Lite master side
    axi_lite_if.master         bus
);

    mem_sys_pkg::port_state_t state;
    mem_sys_pkg::port_state_t next_state;

    // Write with no byte selected is not a request at all
    logic write_req;
    // Stall rises combinationally, falls on a clock edge
    logic comb_stall;
    logic seq_stall;
    // One-cycle pulse after the last handshake of a transaction
    logic done;
    logic tx_end;

    assign write_req  = write_enable & (|byte_enable);
    assign comb_stall = (next_state != mem_sys_pkg::IDLE) && (read_enable || write_req);
    // Done pulse masks the stall so the CPU can retire the request
    assign stall      = (comb_stall || seq_stall) && !done;

    // ==================================================
    // Payloads follow the CPU operands directly
    // ==================================================
    // CPU holds its operands while stalled, so payloads stay stable
    assign bus.awaddr = {address[mem_sys_pkg::ADDR_W-1:mem_sys_pkg::OFFSET_W],
                         {mem_sys_pkg::OFFSET_W{1'b0}}};
    assign bus.araddr = {address[mem_sys_pkg::ADDR_W-1:mem_sys_pkg::OFFSET_W],
                         {mem_sys_pkg::OFFSET_W{1'b0}}};
    assign bus.wdata  = write_data;
    assign bus.wstrb  = byte_enable;

    // ==================================================
    // State, stall and done registers
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= mem_sys_pkg::IDLE;
            seq_stall <= 1'b0;
            done      <= 1'b0;
        end else begin
            state     <= next_state;
            seq_stall <= comb_stall;
            done      <= tx_end;
        end
    end

    // Last read word stays visible until the next read lands
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            read_data <= '0;
        end else if (state == mem_sys_pkg::RECV_READ_DATA && bus.rvalid && bus.rready) begin
            read_data <= bus.rdata;
        end
    end

    // ==================================================
    // Next state and channel handshakes
    // ==================================================
    always_comb begin
        next_state  = state;
        tx_end      = 1'b0;
        // All channels quiet unless the state says otherwise
        bus.awvalid = 1'b0;
        bus.wvalid  = 1'b0;
        bus.bready  = 1'b0;
        bus.arvalid = 1'b0;
        bus.rready  = 1'b0;

        case (state)
            mem_sys_pkg::IDLE: begin
                // Hold off one cycle after done so the CPU can drop the request
                if (!done) begin
                    if (read_enable) begin
                        next_state = mem_sys_pkg::SEND_READ_ADDR;
                    end else if (write_req) begin
                        next_state = mem_sys_pkg::SEND_WRITE_ADDR;
                    end
                end
            end
            mem_sys_pkg::SEND_WRITE_ADDR: begin
                bus.awvalid = 1'b1;
                if (bus.awready) begin
                    next_state = mem_sys_pkg::SEND_WRITE_DATA;
                end
            end
            mem_sys_pkg::SEND_WRITE_DATA: begin
                bus.wvalid = 1'b1;
                if (bus.wready) begin
                    next_state = mem_sys_pkg::WAIT_WRITE_RESP;
                end
            end
            mem_sys_pkg::WAIT_WRITE_RESP: begin
                // Response code ignored, banks only ever answer OKAY
                bus.bready = 1'b1;
                if (bus.bvalid) begin
                    next_state = mem_sys_pkg::IDLE;
                    tx_end     = 1'b1;
                end
            end
            mem_sys_pkg::SEND_READ_ADDR: begin
                bus.arvalid = 1'b1;
                if (bus.arready) begin
                    next_state = mem_sys_pkg::RECV_READ_DATA;
                end
            end
            mem_sys_pkg::RECV_READ_DATA: begin
                bus.rready = 1'b1;
                if (bus.rvalid) begin
                    next_state = mem_sys_pkg::IDLE;
                    tx_end     = 1'b1;
                end
            end
            default: begin
                // Unused encodings fall back to idle
                next_state = mem_sys_pkg::IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" \
    && verilator --binary --timing --timescale 1ns/1ps -f filelist.f \
        --top-module data_mem_tb -o data_mem_sim \
    && ./obj_dir/data_mem_sim | tee /dev/stderr | grep -qx "PASS: all tests" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: tests/data_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem_tb;

    localparam int NUM_BANKS    = 4;
    localparam int BANK_WORDS   = 64;
    // Words in the whole bank row, higher word addresses alias
    localparam int DEPTH        = NUM_BANKS * BANK_WORDS;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_OPS      = 22;

    // One table row: write or read, byte address, byte enable, random data
    typedef struct packed {
        logic               is_write;
        mem_sys_pkg::addr_t addr;
        mem_sys_pkg::strb_t be;
        logic               rand_data;
    } op_t;

    // ==================================================
    // Stimulus table
    // ==================================================
    localparam op_t OPS [NUM_OPS] = '{
        // Full words into four consecutive banks
        '{1'b1, 32'h0000_0000, 4'hF, 1'b1},
        '{1'b1, 32'h0000_0004, 4'hF, 1'b1},
        '{1'b1, 32'h0000_0008, 4'hF, 1'b1},
        '{1'b1, 32'h0000_000C, 4'hF, 1'b1},
        '{1'b0, 32'h0000_0000, 4'hF, 1'b0},
        '{1'b0, 32'h0000_0004, 4'hF, 1'b0},
        '{1'b0, 32'h0000_0008, 4'hF, 1'b0},
        '{1'b0, 32'h0000_000C, 4'hF, 1'b0},
        // Bytes 0 and 2 only
        '{1'b1, 32'h0000_0004, 4'h5, 1'b1},
        '{1'b0, 32'h0000_0004, 4'hF, 1'b0},
        // No byte selected, memory untouched
        '{1'b1, 32'h0000_0008, 4'h0, 1'b1},
        '{1'b0, 32'h0000_0008, 4'hF, 1'b0},
        // Writes between reads leave read_data alone
        '{1'b1, 32'h0000_0010, 4'hF, 1'b0},
        '{1'b1, 32'h0000_000C, 4'hA, 1'b1},
        '{1'b0, 32'h0000_0010, 4'hF, 1'b0},
        '{1'b0, 32'h0000_000C, 4'hF, 1'b0},
        // Aliasing beyond the bank row capacity
        '{1'b1, 32'h0000_0414, 4'hF, 1'b1},
        '{1'b0, 32'h0000_0014, 4'hF, 1'b0},
        '{1'b1, 32'h0000_0800, 4'h3, 1'b1},
        '{1'b0, 32'h0000_0000, 4'hF, 1'b0},
        '{1'b0, 32'h0000_C00C, 4'hF, 1'b0},
        // Byte offset bits ignored
        '{1'b0, 32'h0000_0006, 4'hF, 1'b0}
    };

    logic               clk;
    logic               rst_n;
    mem_sys_pkg::addr_t address;
    mem_sys_pkg::word_t write_data;
    logic               read_enable;
    logic               write_enable;
    mem_sys_pkg::strb_t byte_enable;
    mem_sys_pkg::word_t read_data;
    logic               stall;

    // Expected memory contents and last word read back
    mem_sys_pkg::word_t shadow [DEPTH];
    mem_sys_pkg::word_t last_read;
    logic [31:0]        lfsr;
    int                 errors;

    data_mem_top #(
        .NUM_BANKS  (NUM_BANKS),
        .BANK_WORDS (BANK_WORDS)
    ) dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .address      (address),
        .write_data   (write_data),
        .read_enable  (read_enable),
        .write_enable (write_enable),
        .byte_enable  (byte_enable),
        .read_data    (read_data),
        .stall        (stall)
    );

    // Port FSM state, named in the timeout report
    mem_sys_pkg::port_state_t port_state;
    assign port_state = dut_i.u_port.state;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ==================================================
    // Random data and compare helpers
    // ==================================================
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // One LFSR step per data bit
    task automatic draw_word(output mem_sys_pkg::word_t w);
        w = '0;
        for (int i = 0; i < mem_sys_pkg::DATA_W; i++) begin
            lfsr = lfsr_next(lfsr);
            w    = {w[mem_sys_pkg::DATA_W-2:0], lfsr[0]};
        end
    endtask

    task automatic check_word(input string name, input mem_sys_pkg::word_t exp,
                              input mem_sys_pkg::word_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // ==================================================
    // One table row through the CPU port
    // ==================================================
    task automatic run_op(input op_t op);
        mem_sys_pkg::word_t wdata;
        mem_sys_pkg::addr_t word_addr;
        int                 idx;
        int                 b;
        wdata     = '0;
        word_addr = op.addr >> mem_sys_pkg::OFFSET_W;
        idx       = int'(word_addr % mem_sys_pkg::addr_t'(DEPTH));
        @(posedge clk);
        address     <= op.addr;
        byte_enable <= op.be;
        if (op.is_write) begin
            if (op.rand_data) begin
                draw_word(wdata);
            end else begin
                wdata = op.addr ^ 32'h5A5A_A5A5;
            end
            write_data   <= wdata;
            write_enable <= 1'b1;
        end else begin
            read_enable <= 1'b1;
        end
        // First cycle, stall up for any real request
        @(negedge clk);
        check_bit("stall", !(op.is_write && op.be == '0), stall);
        // Watchdog bounds this wait
        while (stall) begin
            @(negedge clk);
        end
        // Completion cycle
        if (op.is_write) begin
            for (b = 0; b < mem_sys_pkg::STRB_W; b++) begin
                if (op.be[b]) begin
                    shadow[idx][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end else begin
            last_read = shadow[idx];
        end
        check_word("read_data", last_read, read_data);
        @(posedge clk);
        read_enable  <= 1'b0;
        write_enable <= 1'b0;
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        errors       = 0;
        last_read    = '0;
        lfsr         = 32'd94242;
        rst_n        = 1'b0;
        address      = '0;
        write_data   = '0;
        read_enable  = 1'b0;
        write_enable = 1'b0;
        byte_enable  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        // Quiet port straight out of reset
        @(negedge clk);
        check_bit("stall", 1'b0, stall);
        check_word("read_data", '0, read_data);
        for (int n = 0; n < NUM_OPS; n++) begin
            run_op(OPS[n]);
        end
        @(posedge clk);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Generous budget per row plus the reset time
    initial begin
        repeat (NUM_OPS * 30 + RESET_CYCLES) @(posedge clk);
        $display("Run timed out waiting for the port to finish a request, port state %s",
                 port_state.name());
        $display("Errors: %0d", errors);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
